/* mem_stage_pkg.sv */
package mem_stage_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] reg_addr_t;

	// access width, same coding as funct3 of loads and stores
	typedef logic [2:0] width_t;

	localparam width_t W_BYTE   = 3'b000;
	localparam width_t W_HALF   = 3'b001;
	localparam width_t W_WORD   = 3'b010;
	localparam width_t W_BYTE_U = 3'b100;
	localparam width_t W_HALF_U = 3'b101;

	// ram depth in words, indexed by address bits 9:2
	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// cycles of ram_busy after each request
	localparam int RAM_WAIT  = 2;
	localparam int RAM_CNT_W = $clog2(RAM_WAIT + 1);

	// memory access state machine
	typedef enum logic {
		ACC_IDLE,
		ACC_WAIT
	} access_state_t;

endpackage

/* ex_ma_reg.sv */
`timescale 1ns/1ps

module ex_ma_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rdy,
	input  logic                      stall_req,
	input  logic                      ex_we,
	input  mem_stage_pkg::reg_addr_t  ex_waddr,
	input  mem_stage_pkg::word_t      ex_wdata,
	input  logic                      ex_mem_we,
	input  logic                      ex_mem_re,
	input  mem_stage_pkg::width_t     ex_mem_width,
	input  mem_stage_pkg::word_t      ex_mem_addr,
	input  mem_stage_pkg::word_t      ex_mem_wdata,
	output logic                      ma_we,
	output mem_stage_pkg::reg_addr_t  ma_waddr,
	output mem_stage_pkg::word_t      ma_wdata,
	output logic                      ma_mem_we,
	output logic                      ma_mem_re,
	output mem_stage_pkg::width_t     ma_mem_width,
	output mem_stage_pkg::word_t      ma_mem_addr,
	output mem_stage_pkg::word_t      ma_mem_wdata
);

	// new operation only when not frozen and not stalled
	logic capture;

	assign capture = rdy && !stall_req;

	always_ff @(posedge clk) begin
		if (rst) begin
			ma_we        <= 1'b0;
			ma_waddr     <= '0;
			ma_wdata     <= '0;
			ma_mem_we    <= 1'b0;
			ma_mem_re    <= 1'b0;
			ma_mem_width <= '0;
			ma_mem_addr  <= '0;
			ma_mem_wdata <= '0;
		end else if (capture) begin
			ma_we        <= ex_we;
			ma_waddr     <= ex_waddr;
			ma_wdata     <= ex_wdata;
			ma_mem_we    <= ex_mem_we;
			ma_mem_re    <= ex_mem_re;
			ma_mem_width <= ex_mem_width;
			ma_mem_addr  <= ex_mem_addr;
			ma_mem_wdata <= ex_mem_wdata;
		end
	end

	// execute never hands over a load and a store at once
	a_no_ld_st: assert property (@(posedge clk) disable iff (rst)
		capture |-> !(ex_mem_we && ex_mem_re));

endmodule

/* mem_access.sv */
`timescale 1ns/1ps

module mem_access (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rdy,
	input  logic                      ma_we,
	input  mem_stage_pkg::reg_addr_t  ma_waddr,
	input  mem_stage_pkg::word_t      ma_wdata,
	input  logic                      ma_mem_we,
	input  logic                      ma_mem_re,
	input  mem_stage_pkg::width_t     ma_mem_width,
	input  mem_stage_pkg::word_t      ma_mem_addr,
	input  mem_stage_pkg::word_t      ma_mem_wdata,
	input  mem_stage_pkg::word_t      ram_rdata,
	input  logic                      ram_busy,
	output logic                      ram_req,
	output logic                      ram_we,
	output mem_stage_pkg::width_t     ram_width,
	output mem_stage_pkg::word_t      ram_addr,
	output mem_stage_pkg::word_t      ram_wdata,
	output logic                      stall_req,
	output logic                      wb_we_next,
	output mem_stage_pkg::reg_addr_t  wb_waddr_next,
	output mem_stage_pkg::word_t      wb_wdata_next
);

	mem_stage_pkg::access_state_t state;
	logic                         mem_op;
	logic                         done;
	logic [7:0]                   ld_byte;
	logic [15:0]                  ld_half;
	mem_stage_pkg::word_t         ld_ext;

	assign mem_op = ma_mem_we || ma_mem_re;
	// busy has fallen after our request, data is on ram_rdata now
	assign done   = (state == mem_stage_pkg::ACC_WAIT) && !ram_busy;

	// one request per operation, only from idle
	assign ram_req   = mem_op && (state == mem_stage_pkg::ACC_IDLE);
	assign ram_we    = ma_mem_we;
	assign ram_width = ma_mem_width;
	assign ram_addr  = ma_mem_addr;
	assign ram_wdata = ma_mem_wdata;

	// hold the pipe from request until completion
	assign stall_req = mem_op && !done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_stage_pkg::ACC_IDLE;
		end else if (rdy) begin
			case (state)
				mem_stage_pkg::ACC_IDLE: begin
					if (mem_op) begin
						state <= mem_stage_pkg::ACC_WAIT;
					end
				end
				mem_stage_pkg::ACC_WAIT: begin
					if (!ram_busy) begin
						state <= mem_stage_pkg::ACC_IDLE;
					end
				end
				default: state <= mem_stage_pkg::ACC_IDLE;
			endcase
		end
	end

	// pick the addressed lane out of the read word
	always_comb begin
		case (ma_mem_addr[1:0])
			2'd0:    ld_byte = ram_rdata[7:0];
			2'd1:    ld_byte = ram_rdata[15:8];
			2'd2:    ld_byte = ram_rdata[23:16];
			default: ld_byte = ram_rdata[31:24];
		endcase
		ld_half = ma_mem_addr[1] ? ram_rdata[31:16] : ram_rdata[15:0];
		case (ma_mem_width)
			mem_stage_pkg::W_BYTE:   ld_ext = {{24{ld_byte[7]}}, ld_byte};
			mem_stage_pkg::W_BYTE_U: ld_ext = {24'h0, ld_byte};
			mem_stage_pkg::W_HALF:   ld_ext = {{16{ld_half[15]}}, ld_half};
			mem_stage_pkg::W_HALF_U: ld_ext = {16'h0, ld_half};
			default:                 ld_ext = ram_rdata;
		endcase
	end

	// no writeback until the access has finished
	assign wb_we_next    = ma_we && !stall_req;
	assign wb_waddr_next = ma_waddr;
	assign wb_wdata_next = (ma_mem_re && done) ? ld_ext : ma_wdata;

	// pending access keeps its operation parked in ex/ma until done
	a_wait_op_held: assert property (@(posedge clk) disable iff (rst)
		(state == mem_stage_pkg::ACC_WAIT) |-> mem_op);

	// aligned accesses only
	a_half_align: assert property (@(posedge clk) disable iff (rst)
		ram_req && (ram_width == mem_stage_pkg::W_HALF ||
			ram_width == mem_stage_pkg::W_HALF_U) |-> !ram_addr[0]);
	a_word_align: assert property (@(posedge clk) disable iff (rst)
		ram_req && (ram_width == mem_stage_pkg::W_WORD) |-> ram_addr[1:0] == 2'b00);

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rdy,
	input  logic                   ram_req,
	input  logic                   ram_we,
	input  mem_stage_pkg::width_t  ram_width,
	input  mem_stage_pkg::word_t   ram_addr,
	input  mem_stage_pkg::word_t   ram_wdata,
	output mem_stage_pkg::word_t   ram_rdata,
	output logic                   ram_busy
);

	mem_stage_pkg::word_t                mem [mem_stage_pkg::RAM_WORDS];
	logic [mem_stage_pkg::RAM_IDX_W-1:0] idx;
	logic [mem_stage_pkg::RAM_CNT_W-1:0] busy_cnt;
	logic [3:0]                          be;
	mem_stage_pkg::word_t                lane_data;

	// word index from address bits 9:2
	assign idx = ram_addr[mem_stage_pkg::RAM_IDX_W+1:2];

	// byte enables from width and low address bits
	always_comb begin
		case (ram_width)
			mem_stage_pkg::W_BYTE,
			mem_stage_pkg::W_BYTE_U: be = 4'b0001 << ram_addr[1:0];
			mem_stage_pkg::W_HALF,
			mem_stage_pkg::W_HALF_U: be = ram_addr[1] ? 4'b1100 : 4'b0011;
			mem_stage_pkg::W_WORD:   be = 4'b1111;
			default:                 be = 4'b0000;
		endcase
	end

	// store data sits in the low bits, move it up to its lane
	assign lane_data = ram_wdata << {ram_addr[1:0], 3'b000};

	// countdown for the busy window
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_cnt <= '0;
		end else if (rdy) begin
			if (ram_req) begin
				busy_cnt <= mem_stage_pkg::RAM_CNT_W'(mem_stage_pkg::RAM_WAIT);
			end else if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - 1'b1;
			end
		end
	end

	assign ram_busy = (busy_cnt != '0);

	// array write and registered read, both at the request edge
	always_ff @(posedge clk) begin
		if (rdy && ram_req) begin
			ram_rdata <= mem[idx];
			if (ram_we) begin
				for (int i = 0; i < 4; i++) begin
					if (be[i]) begin
						mem[idx][i*8 +: 8] <= lane_data[i*8 +: 8];
					end
				end
			end
		end
	end

	// master must wait out the busy window
	a_req_idle: assert property (@(posedge clk) disable iff (rst)
		ram_req |-> !ram_busy);

endmodule

/* ma_wb_reg.sv */
`timescale 1ns/1ps

module ma_wb_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rdy,
	input  logic                      wb_we_next,
	input  mem_stage_pkg::reg_addr_t  wb_waddr_next,
	input  mem_stage_pkg::word_t      wb_wdata_next,
	output logic                      wb_we,
	output mem_stage_pkg::reg_addr_t  wb_waddr,
	output mem_stage_pkg::word_t      wb_wdata
);

	// x0 is hardwired zero, drop the write here
	logic we_keep;

	assign we_keep = wb_we_next && (wb_waddr_next != '0);

	// advances on every rdy edge, stall handling is upstream
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we    <= 1'b0;
			wb_waddr <= '0;
			wb_wdata <= '0;
		end else if (rdy) begin
			wb_we    <= we_keep;
			wb_waddr <= wb_waddr_next;
			wb_wdata <= wb_wdata_next;
		end
	end

endmodule

/* mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rdy,
	input  logic                      ex_we,
	input  mem_stage_pkg::reg_addr_t  ex_waddr,
	input  mem_stage_pkg::word_t      ex_wdata,
	input  logic                      ex_mem_we,
	input  logic                      ex_mem_re,
	input  mem_stage_pkg::width_t     ex_mem_width,
	input  mem_stage_pkg::word_t      ex_mem_addr,
	input  mem_stage_pkg::word_t      ex_mem_wdata,
	output logic                      stall,
	output logic                      wb_we,
	output mem_stage_pkg::reg_addr_t  wb_waddr,
	output mem_stage_pkg::word_t      wb_wdata
);

	// ex/ma register outputs
	logic                      ma_we;
	mem_stage_pkg::reg_addr_t  ma_waddr;
	mem_stage_pkg::word_t      ma_wdata;
	logic                      ma_mem_we;
	logic                      ma_mem_re;
	mem_stage_pkg::width_t     ma_mem_width;
	mem_stage_pkg::word_t      ma_mem_addr;
	mem_stage_pkg::word_t      ma_mem_wdata;

	// ram handshake
	logic                      ram_req;
	logic                      ram_we;
	mem_stage_pkg::width_t     ram_width;
	mem_stage_pkg::word_t      ram_addr;
	mem_stage_pkg::word_t      ram_wdata;
	mem_stage_pkg::word_t      ram_rdata;
	logic                      ram_busy;

	// writeback toward ma/wb
	logic                      wb_we_next;
	mem_stage_pkg::reg_addr_t  wb_waddr_next;
	mem_stage_pkg::word_t      wb_wdata_next;

	ex_ma_reg u_ex_ma_reg (
		.clk          (clk),
		.rst          (rst),
		.rdy          (rdy),
		.stall_req    (stall),
		.ex_we        (ex_we),
		.ex_waddr     (ex_waddr),
		.ex_wdata     (ex_wdata),
		.ex_mem_we    (ex_mem_we),
		.ex_mem_re    (ex_mem_re),
		.ex_mem_width (ex_mem_width),
		.ex_mem_addr  (ex_mem_addr),
		.ex_mem_wdata (ex_mem_wdata),
		.ma_we        (ma_we),
		.ma_waddr     (ma_waddr),
		.ma_wdata     (ma_wdata),
		.ma_mem_we    (ma_mem_we),
		.ma_mem_re    (ma_mem_re),
		.ma_mem_width (ma_mem_width),
		.ma_mem_addr  (ma_mem_addr),
		.ma_mem_wdata (ma_mem_wdata)
	);

	// stall_req goes both to ex/ma and out as stall
	mem_access u_mem_access (
		.clk           (clk),
		.rst           (rst),
		.rdy           (rdy),
		.ma_we         (ma_we),
		.ma_waddr      (ma_waddr),
		.ma_wdata      (ma_wdata),
		.ma_mem_we     (ma_mem_we),
		.ma_mem_re     (ma_mem_re),
		.ma_mem_width  (ma_mem_width),
		.ma_mem_addr   (ma_mem_addr),
		.ma_mem_wdata  (ma_mem_wdata),
		.ram_rdata     (ram_rdata),
		.ram_busy      (ram_busy),
		.ram_req       (ram_req),
		.ram_we        (ram_we),
		.ram_width     (ram_width),
		.ram_addr      (ram_addr),
		.ram_wdata     (ram_wdata),
		.stall_req     (stall),
		.wb_we_next    (wb_we_next),
		.wb_waddr_next (wb_waddr_next),
		.wb_wdata_next (wb_wdata_next)
	);

	data_ram u_data_ram (
		.clk       (clk),
		.rst       (rst),
		.rdy       (rdy),
		.ram_req   (ram_req),
		.ram_we    (ram_we),
		.ram_width (ram_width),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata),
		.ram_busy  (ram_busy)
	);

	ma_wb_reg u_ma_wb_reg (
		.clk           (clk),
		.rst           (rst),
		.rdy           (rdy),
		.wb_we_next    (wb_we_next),
		.wb_waddr_next (wb_waddr_next),
		.wb_wdata_next (wb_wdata_next),
		.wb_we         (wb_we),
		.wb_waddr      (wb_waddr),
		.wb_wdata      (wb_wdata)
	);

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;

	// seven hex columns per operation in the pattern file
	localparam int COLS    = 7;
	localparam int PAT_MAX = 64;

	logic                      clk;
	logic                      rst;
	logic                      rdy;
	logic                      ex_we;
	mem_stage_pkg::reg_addr_t  ex_waddr;
	mem_stage_pkg::word_t      ex_wdata;
	logic                      ex_mem_we;
	logic                      ex_mem_re;
	mem_stage_pkg::width_t     ex_mem_width;
	mem_stage_pkg::word_t      ex_mem_addr;
	mem_stage_pkg::word_t      ex_mem_wdata;
	logic                      stall;
	logic                      wb_we;
	mem_stage_pkg::reg_addr_t  wb_waddr;
	mem_stage_pkg::word_t      wb_wdata;

	// raw pattern words and the expected writeback list built from them
	mem_stage_pkg::word_t      pat [PAT_MAX*COLS];
	mem_stage_pkg::reg_addr_t  exp_rd [PAT_MAX];
	mem_stage_pkg::word_t      exp_val [PAT_MAX];

	int     n_ops       = 0;
	int     n_exp       = 0;
	int     mon_idx     = 0;
	int     err_main    = 0;
	int     err_mon     = 0;
	int     cycles      = 0;
	int     cycle_limit = 0;
	integer seed        = 32'h394b_7fed;

	mem_stage_top u_mem_stage_top (
		.clk          (clk),
		.rst          (rst),
		.rdy          (rdy),
		.ex_we        (ex_we),
		.ex_waddr     (ex_waddr),
		.ex_wdata     (ex_wdata),
		.ex_mem_we    (ex_mem_we),
		.ex_mem_re    (ex_mem_re),
		.ex_mem_width (ex_mem_width),
		.ex_mem_addr  (ex_mem_addr),
		.ex_mem_wdata (ex_mem_wdata),
		.stall        (stall),
		.wb_we        (wb_we),
		.wb_waddr     (wb_waddr),
		.wb_wdata     (wb_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// empty slot, nothing to write back and no memory access
	task automatic drive_bubble();
		ex_we        = 1'b0;
		ex_waddr     = '0;
		ex_wdata     = '0;
		ex_mem_we    = 1'b0;
		ex_mem_re    = 1'b0;
		ex_mem_width = '0;
		ex_mem_addr  = '0;
		ex_mem_wdata = '0;
	endtask

	// kind 0 alu result, 1 store, 2 load
	task automatic drive_op(input int i);
		mem_stage_pkg::word_t kind;
		kind         = pat[i*COLS];
		ex_we        = (kind != 32'h1);
		ex_waddr     = pat[i*COLS+4][4:0];
		ex_wdata     = (kind == 32'h0) ? pat[i*COLS+3] : '0;
		ex_mem_we    = (kind == 32'h1);
		ex_mem_re    = (kind == 32'h2);
		ex_mem_width = pat[i*COLS+1][2:0];
		ex_mem_addr  = pat[i*COLS+2];
		ex_mem_wdata = (kind == 32'h1) ? pat[i*COLS+3] : '0;
	endtask

	// writeback is taken on an edge with rdy high, rdy is stable here
	always @(negedge clk) begin
		if (!rst && rdy && wb_we === 1'b1) begin
			if (mon_idx >= n_exp) begin
				$display("extra writeback to x%0d with value %h at %0t, none was expected",
					wb_waddr, wb_wdata, $time);
				err_mon++;
			end else begin
				if (wb_waddr !== exp_rd[mon_idx]) begin
					$display("ERROR t=%0t wb_waddr expected %0d got %0d",
						$time, exp_rd[mon_idx], wb_waddr);
					err_mon++;
				end
				if (wb_wdata !== exp_val[mon_idx]) begin
					$display("ERROR t=%0t wb_wdata expected %h got %h",
						$time, exp_val[mon_idx], wb_wdata);
					err_mon++;
				end
				mon_idx++;
			end
		end
	end

	// run limit scales with the number of operations
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d writebacks seen",
				cycles, mon_idx, n_exp);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		integer rnd;
		int     op_idx;
		int     stall_cnt;
		int     exp_stall;
		logic   taken;
		logic   fresh;
		logic   ma_is_mem;
		logic   drv_is_mem;
		rst        = 1'b1;
		rdy        = 1'b1;
		drive_bubble();
		fresh      = 1'b0;
		ma_is_mem  = 1'b0;
		drv_is_mem = 1'b0;
		op_idx     = 0;
		stall_cnt  = 0;
		exp_stall  = 0;
		$readmemh("mem_stage_patterns.txt", pat);
		while (n_ops < PAT_MAX && pat[n_ops*COLS] != 32'hf) begin
			if (pat[n_ops*COLS+5] == 32'h1) begin
				exp_rd[n_exp]  = pat[n_ops*COLS+4][4:0];
				exp_val[n_exp] = pat[n_ops*COLS+6];
				n_exp++;
			end
			n_ops++;
		end
		if (n_ops == 0) begin
			$display("no operations could be read from the pattern file");
			err_main++;
		end
		cycle_limit = n_ops * (mem_stage_pkg::RAM_WAIT + 4) * 2 + 20;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		// quiet pipe after reset
		repeat (4) begin
			@(negedge clk);
			if (stall !== 1'b0) begin
				$display("ERROR t=%0t stall expected 0 got %b", $time, stall);
				err_main++;
			end
			if (wb_we !== 1'b0) begin
				$display("ERROR t=%0t wb_we expected 0 got %b", $time, wb_we);
				err_main++;
			end
		end
		@(posedge clk);
		#1;
		if (n_ops > 0) begin
			drive_op(0);
			drv_is_mem = (pat[0] != 32'h0);
		end
		while (op_idx < n_ops) begin
			@(negedge clk);
			// a fresh memory op stalls at once, an alu op never does
			if (fresh) begin
				if (stall !== ma_is_mem) begin
					$display("ERROR t=%0t stall expected %b got %b", $time, ma_is_mem, stall);
					err_main++;
				end
				fresh = 1'b0;
			end
			taken = rdy && !stall;
			// request cycle plus the busy window, counted on live edges only
			if (rdy && stall === 1'b1) begin
				stall_cnt++;
			end
			if (taken) begin
				exp_stall = ma_is_mem ? mem_stage_pkg::RAM_WAIT + 1 : 0;
				if (stall_cnt != exp_stall) begin
					$display("ERROR t=%0t stall cycles expected %0d got %0d",
						$time, exp_stall, stall_cnt);
					err_main++;
				end
				stall_cnt = 0;
			end
			@(posedge clk);
			#1;
			if (taken) begin
				ma_is_mem = drv_is_mem;
				fresh     = 1'b1;
				op_idx++;
				if (op_idx < n_ops) begin
					drive_op(op_idx);
					drv_is_mem = (pat[op_idx*COLS] != 32'h0);
				end else begin
					drive_bubble();
					drv_is_mem = 1'b0;
				end
			end
			rnd = $random(seed);
			rdy = (rnd[1:0] != 2'b00);
		end
		// let the last writebacks drain, still with rdy gaps
		while (mon_idx < n_exp) begin
			@(posedge clk);
			#1;
			rnd = $random(seed);
			rdy = (rnd[1:0] != 2'b00);
		end
		rdy = 1'b1;
		repeat (8) @(posedge clk);
		$display("%0d operations, %0d writebacks checked, %0d errors",
			n_ops, mon_idx, err_main + err_mon);
		if (err_main + err_mon == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* mem_stage_patterns.txt */
// kind: 0 alu, 1 store, 2 load, f end; width: funct3 code; all values hex
// columns: kind width addr data rd wb_valid wb_value
0 2 00000000 00001111 01 1 00001111
0 2 00000000 deadbeef 02 1 deadbeef
0 2 00000000 12345678 00 0 00000000
0 2 00000000 0000abcd 1f 1 0000abcd
1 2 00000010 cafef00d 00 0 00000000
2 2 00000010 00000000 03 1 cafef00d
1 2 00000020 11223344 00 0 00000000
1 0 00000021 000000aa 00 0 00000000
1 1 00000022 0000beef 00 0 00000000
1 4 00000020 0000005a 00 0 00000000
2 2 00000020 00000000 04 1 beefaa5a
1 2 00000030 80ff7f01 00 0 00000000
2 0 00000030 00000000 06 1 00000001
2 0 00000031 00000000 07 1 0000007f
2 0 00000032 00000000 08 1 ffffffff
2 0 00000033 00000000 09 1 ffffff80
2 4 00000030 00000000 0a 1 00000001
2 4 00000031 00000000 0b 1 0000007f
2 4 00000032 00000000 0c 1 000000ff
2 4 00000033 00000000 0d 1 00000080
2 1 00000030 00000000 0e 1 00007f01
2 1 00000032 00000000 0f 1 ffff80ff
2 5 00000030 00000000 10 1 00007f01
2 5 00000032 00000000 11 1 000080ff
2 0 00000021 00000000 12 1 ffffffaa
2 4 00000021 00000000 13 1 000000aa
2 1 00000022 00000000 14 1 ffffbeef
2 5 00000020 00000000 15 1 0000aa5a
2 2 00000030 00000000 00 0 00000000
0 2 00000000 00000042 05 1 00000042
f 0 00000000 00000000 00 0 00000000

/* mem_stage.f */
mem_stage_pkg.sv
ex_ma_reg.sv
mem_access.sv
data_ram.sv
ma_wb_reg.sv
mem_stage_top.sv
tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -sv \
	--top-module tb_mem_stage \
	-f mem_stage.f \
	-o sim_mem_stage
./obj_dir/sim_mem_stage | tee sim.log
grep -qx "sim passed" sim.log
echo "run_sim: pass message found"
